// ==== Bender.yml ====
package:
  name: cpu_slice

sources:
  - design/cpu_pkg.sv
  - design/cpu_decoder.sv
  - design/cpu_registers.sv
  - design/cpu_bypass.sv
  - design/cpu_execute.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - testbench/tb_cpu_top.sv

// ==== design/cpu_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bypass (
        input  wire logic                         i_clock,
        input  wire logic                         i_reset,
        input  wire logic [4:0]                   i_rs1_index,
        input  wire logic [4:0]                   i_rs2_index,
        input  wire logic [31:0]                  i_rs1_file,
        input  wire logic [31:0]                  i_rs2_file,
        input  wire logic [4:0]                   i_wb_rd,
        input  wire logic [31:0]                  i_wb_value,
        input  wire logic [cpu_pkg::TAG_BITS-1:0] i_wb_tag,
        output logic [31:0]                       o_rs1,
        output logic [31:0]                       o_rs2
);
        logic [cpu_pkg::TAG_BITS-1:0] seen_tag;
        logic                         held_valid;
        logic [4:0]                   held_rd;
        logic [31:0]                  held_value;
        logic                         wb_new;

        assign wb_new = (i_wb_tag != seen_tag);

        // newest result first then the one being written this cycle
        function automatic logic [31:0] select_operand(input logic [4:0]  index,
                                                       input logic [31:0] file_value);
                if (index != 5'd0 && index == i_wb_rd)
                        return i_wb_value;
                if (held_valid && index != 5'd0 && index == held_rd)
                        return held_value;
                return file_value;
        endfunction

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        seen_tag   <= '0;
                        held_valid <= 1'b0;
                        held_rd    <= 5'd0;
                end else if (wb_new) begin
                        seen_tag   <= i_wb_tag;
                        held_valid <= 1'b1;
                        held_rd    <= i_wb_rd;
                end
        end

        always_ff @(posedge i_clock) begin
                if (wb_new) held_value <= i_wb_value;
        end

        always_comb begin
                o_rs1 = select_operand(i_rs1_index, i_rs1_file);
                o_rs2 = select_operand(i_rs2_index, i_rs2_file);
        end

endmodule

`default_nettype wire

// ==== design/cpu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder (
        input  wire logic                         i_clock,
        input  wire logic                         i_reset,
        input  wire cpu_pkg::rv_instr_t           i_fetch_instruction,
        input  wire logic [cpu_pkg::TAG_BITS-1:0] i_fetch_tag,
        output cpu_pkg::alu_op_t                  o_alu_op,
        output logic [4:0]                        o_rd,
        output logic [4:0]                        o_rs1_index,
        output logic [4:0]                        o_rs2_index,
        output logic                              o_use_imm,
        output logic [31:0]                       o_imm,
        output logic [cpu_pkg::TAG_BITS-1:0]      o_tag
);
        cpu_pkg::alu_op_t alu_op;
        logic             use_imm;
        logic [4:0]       rd;
        logic             fetch_new;

        assign fetch_new = (i_fetch_tag != o_tag);

        always_comb begin
                alu_op  = cpu_pkg::ALU_NONE;
                use_imm = 1'b0;
                case (i_fetch_instruction.r_type.opcode)
                        cpu_pkg::OPCODE_OP: begin
                                if (i_fetch_instruction.r_type.funct7 == cpu_pkg::F7_BASE) begin
                                        case (i_fetch_instruction.r_type.funct3)
                                                cpu_pkg::F3_ADD_SUB: alu_op = cpu_pkg::ALU_ADD;
                                                cpu_pkg::F3_SLL:     alu_op = cpu_pkg::ALU_SLL;
                                                cpu_pkg::F3_SLT:     alu_op = cpu_pkg::ALU_SLT;
                                                cpu_pkg::F3_XOR:     alu_op = cpu_pkg::ALU_XOR;
                                                cpu_pkg::F3_SRL:     alu_op = cpu_pkg::ALU_SRL;
                                                cpu_pkg::F3_OR:      alu_op = cpu_pkg::ALU_OR;
                                                cpu_pkg::F3_AND:     alu_op = cpu_pkg::ALU_AND;
                                                default:             alu_op = cpu_pkg::ALU_NONE; // sltu
                                        endcase
                                end else if (i_fetch_instruction.r_type.funct7 == cpu_pkg::F7_ALT &&
                                             i_fetch_instruction.r_type.funct3 == cpu_pkg::F3_ADD_SUB) begin
                                        alu_op = cpu_pkg::ALU_SUB;
                                end
                        end
                        cpu_pkg::OPCODE_OP_IMM: begin
                                use_imm = 1'b1;
                                case (i_fetch_instruction.i_type.funct3)
                                        cpu_pkg::F3_ADD_SUB: alu_op = cpu_pkg::ALU_ADD;
                                        cpu_pkg::F3_SLT:     alu_op = cpu_pkg::ALU_SLT;
                                        cpu_pkg::F3_XOR:     alu_op = cpu_pkg::ALU_XOR;
                                        cpu_pkg::F3_OR:      alu_op = cpu_pkg::ALU_OR;
                                        cpu_pkg::F3_AND:     alu_op = cpu_pkg::ALU_AND;
                                        // shift forms keep funct7 in the upper immediate bits
                                        cpu_pkg::F3_SLL: begin
                                                if (i_fetch_instruction.r_type.funct7 == cpu_pkg::F7_BASE)
                                                        alu_op = cpu_pkg::ALU_SLL;
                                        end
                                        cpu_pkg::F3_SRL: begin
                                                if (i_fetch_instruction.r_type.funct7 == cpu_pkg::F7_BASE)
                                                        alu_op = cpu_pkg::ALU_SRL;
                                        end
                                        default: alu_op = cpu_pkg::ALU_NONE; // sltiu
                                endcase
                        end
                        default: alu_op = cpu_pkg::ALU_NONE;
                endcase
                rd = (alu_op == cpu_pkg::ALU_NONE) ? 5'd0 : i_fetch_instruction.i_type.rd;
        end

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        o_tag    <= '0;
                        o_alu_op <= cpu_pkg::ALU_NONE;
                        o_rd     <= 5'd0;
                end else if (fetch_new) begin
                        o_tag    <= i_fetch_tag;
                        o_alu_op <= alu_op;
                        o_rd     <= rd;
                end
        end

        always_ff @(posedge i_clock) begin
                if (fetch_new) begin
                        o_rs1_index <= i_fetch_instruction.r_type.rs1;
                        o_rs2_index <= i_fetch_instruction.r_type.rs2;
                        o_use_imm   <= use_imm;
                        o_imm       <= {{20{i_fetch_instruction.i_type.imm[11]}},
                                        i_fetch_instruction.i_type.imm};
                end
        end

        a_tag_follows_fetch: assert property (@(posedge i_clock) disable iff (i_reset)
                $changed(o_tag) |-> $past(i_fetch_tag != o_tag));

endmodule

`default_nettype wire

// ==== design/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
        input  wire logic                         i_clock,
        input  wire logic                         i_reset,
        input  wire cpu_pkg::alu_op_t             i_alu_op,
        input  wire logic [4:0]                   i_rd,
        input  wire logic                         i_use_imm,
        input  wire logic [31:0]                  i_imm,
        input  wire logic [31:0]                  i_rs1,
        input  wire logic [31:0]                  i_rs2,
        input  wire logic [cpu_pkg::TAG_BITS-1:0] i_tag,
        output logic [4:0]                        o_wb_rd,
        output logic [31:0]                       o_wb_value,
        output logic [cpu_pkg::TAG_BITS-1:0]      o_wb_tag
);
        logic [31:0] operand_b;
        logic [31:0] result;

        assign operand_b = i_use_imm ? i_imm : i_rs2;

        always_comb begin
                case (i_alu_op)
                        cpu_pkg::ALU_ADD: result = i_rs1 + operand_b;
                        cpu_pkg::ALU_SUB: result = i_rs1 - operand_b;
                        cpu_pkg::ALU_SLL: result = i_rs1 << operand_b[4:0];
                        cpu_pkg::ALU_SLT: result = {31'h0, $signed(i_rs1) < $signed(operand_b)};
                        cpu_pkg::ALU_XOR: result = i_rs1 ^ operand_b;
                        cpu_pkg::ALU_SRL: result = i_rs1 >> operand_b[4:0];   // logical only
                        cpu_pkg::ALU_OR:  result = i_rs1 | operand_b;
                        cpu_pkg::ALU_AND: result = i_rs1 & operand_b;
                        default:          result = 32'h0;
                endcase
        end

        // one retire per new decoder tag
        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        o_wb_rd    <= 5'd0;
                        o_wb_value <= 32'h0;
                        o_wb_tag   <= '0;
                end else if (i_tag != o_wb_tag) begin
                        o_wb_rd    <= i_rd;   // rd 0 still retires
                        o_wb_value <= result;
                        o_wb_tag   <= i_tag;
                end
        end

        a_retire_next_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
                $changed(i_tag) |=> (o_wb_tag == $past(i_tag)));

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

        localparam int unsigned TAG_BITS = 2;   // fetch and writeback tags

        localparam logic [6:0] OPCODE_OP     = 7'b0110011;
        localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

        localparam logic [2:0] F3_ADD_SUB = 3'b000;
        localparam logic [2:0] F3_SLL     = 3'b001;
        localparam logic [2:0] F3_SLT     = 3'b010;
        localparam logic [2:0] F3_XOR     = 3'b100;
        localparam logic [2:0] F3_SRL     = 3'b101;
        localparam logic [2:0] F3_OR      = 3'b110;
        localparam logic [2:0] F3_AND     = 3'b111;

        localparam logic [6:0] F7_BASE = 7'b0000000;
        localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra

        typedef enum logic [3:0] {
                ALU_NONE,       // result is zero
                ALU_ADD,
                ALU_SUB,
                ALU_SLL,
                ALU_SLT,
                ALU_XOR,
                ALU_SRL,
                ALU_OR,
                ALU_AND
        } alu_op_t;

        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } r_type;
                struct packed {
                        logic [11:0] imm;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i_type;
        } rv_instr_t;

endpackage

`default_nettype wire

// ==== design/cpu_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_registers #(
        parameter logic [31:0] STACK_POINTER = 32'h0000_1000
) (
        input  wire logic                         i_clock,
        input  wire logic                         i_reset,
        input  wire cpu_pkg::rv_instr_t           i_fetch_instruction,
        output logic [31:0]                       o_rs1,
        output logic [31:0]                       o_rs2,
        input  wire logic [4:0]                   i_wb_rd,
        input  wire logic [31:0]                  i_wb_value,
        input  wire logic [cpu_pkg::TAG_BITS-1:0] i_wb_tag
);
        logic [31:0]                  registers [32];
        logic [cpu_pkg::TAG_BITS-1:0] write_tag;
        logic [4:0]                   rs1_index;
        logic [4:0]                   rs2_index;

        assign rs1_index = i_fetch_instruction.r_type.rs1;
        assign rs2_index = i_fetch_instruction.r_type.rs2;

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        o_rs1     <= 32'h0;
                        o_rs2     <= 32'h0;
                        write_tag <= '0;
                        for (int i = 0; i < 32; i++) begin
                                registers[i] <= (i == 2) ? STACK_POINTER : 32'h0;   // x2 is sp
                        end
                end else begin
                        // read before write so the bypass covers the gap
                        o_rs1 <= (rs1_index != 5'd0) ? registers[rs1_index] : 32'h0;
                        o_rs2 <= (rs2_index != 5'd0) ? registers[rs2_index] : 32'h0;

                        if (i_wb_tag != write_tag) begin
                                if (i_wb_rd != 5'd0) begin
                                        registers[i_wb_rd] <= i_wb_value;
                                end
                                write_tag <= i_wb_tag;
                        end
                end
        end

        a_x0_zero: assert property (@(posedge i_clock) disable iff (i_reset)
                registers[0] == 32'h0);

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
        parameter logic [31:0] STACK_POINTER = 32'h0000_1000
) (
        input  wire logic                         i_clock,
        input  wire logic                         i_reset,
        input  wire logic [31:0]                  i_fetch_instruction,
        input  wire logic [cpu_pkg::TAG_BITS-1:0] i_fetch_tag,
        output logic [4:0]                        o_wb_rd,
        output logic [31:0]                       o_wb_value,
        output logic [cpu_pkg::TAG_BITS-1:0]      o_wb_tag
);
        cpu_pkg::alu_op_t             alu_op;
        logic [4:0]                   rd;
        logic [4:0]                   rs1_index;
        logic [4:0]                   rs2_index;
        logic                         use_imm;
        logic [31:0]                  imm;
        logic [cpu_pkg::TAG_BITS-1:0] decode_tag;
        logic [31:0]                  rs1_file;
        logic [31:0]                  rs2_file;
        logic [31:0]                  rs1;
        logic [31:0]                  rs2;

        cpu_decoder u_decoder (
                .i_clock             (i_clock),
                .i_reset             (i_reset),
                .i_fetch_instruction (i_fetch_instruction),
                .i_fetch_tag         (i_fetch_tag),
                .o_alu_op            (alu_op),
                .o_rd                (rd),
                .o_rs1_index         (rs1_index),
                .o_rs2_index         (rs2_index),
                .o_use_imm           (use_imm),
                .o_imm               (imm),
                .o_tag               (decode_tag)
        );

        cpu_registers #(
                .STACK_POINTER (STACK_POINTER)
        ) u_registers (
                .i_clock             (i_clock),
                .i_reset             (i_reset),
                .i_fetch_instruction (i_fetch_instruction),   // reads straight from fetch
                .o_rs1               (rs1_file),
                .o_rs2               (rs2_file),
                .i_wb_rd             (o_wb_rd),
                .i_wb_value          (o_wb_value),
                .i_wb_tag            (o_wb_tag)
        );

        cpu_bypass u_bypass (
                .i_clock     (i_clock),
                .i_reset     (i_reset),
                .i_rs1_index (rs1_index),
                .i_rs2_index (rs2_index),
                .i_rs1_file  (rs1_file),
                .i_rs2_file  (rs2_file),
                .i_wb_rd     (o_wb_rd),
                .i_wb_value  (o_wb_value),
                .i_wb_tag    (o_wb_tag),
                .o_rs1       (rs1),
                .o_rs2       (rs2)
        );

        cpu_execute u_execute (
                .i_clock    (i_clock),
                .i_reset    (i_reset),
                .i_alu_op   (alu_op),
                .i_rd       (rd),
                .i_use_imm  (use_imm),
                .i_imm      (imm),
                .i_rs1      (rs1),
                .i_rs2      (rs2),
                .i_tag      (decode_tag),
                .o_wb_rd    (o_wb_rd),
                .o_wb_value (o_wb_value),
                .o_wb_tag   (o_wb_tag)
        );

endmodule

`default_nettype wire

// ==== list.f ====
design/cpu_pkg.sv
design/cpu_decoder.sv
design/cpu_registers.sv
design/cpu_bypass.sv
design/cpu_execute.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv

// ==== testbench/tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
        localparam logic [31:0] STACK_POINTER = 32'h0001_fff0;
        localparam int NUM_DIRECTED = 10;
        localparam int NUM_RANDOM   = 400;
        localparam int CYCLE_LIMIT  = 4 * (NUM_DIRECTED + NUM_RANDOM) + 50;

        localparam int OP_ADD = 0;
        localparam int OP_SUB = 1;
        localparam int OP_SLL = 2;
        localparam int OP_SLT = 3;
        localparam int OP_XOR = 4;
        localparam int OP_SRL = 5;
        localparam int OP_OR  = 6;
        localparam int OP_AND = 7;

        int imm_ops [7] = '{OP_ADD, OP_SLT, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL};

        logic                         clock;
        logic                         reset;
        logic [31:0]                  fetch_instruction;
        logic [cpu_pkg::TAG_BITS-1:0] fetch_tag;
        logic [4:0]                   wb_rd;
        logic [31:0]                  wb_value;
        logic [cpu_pkg::TAG_BITS-1:0] wb_tag;

        logic [31:0]                  rng_state;
        logic [31:0]                  model_regs [32];
        logic [cpu_pkg::TAG_BITS-1:0] last_wb_tag;
        logic [4:0]                   exp_rd [$];
        logic [31:0]                  exp_value [$];
        logic [cpu_pkg::TAG_BITS-1:0] exp_tag [$];
        int                           exp_cycle [$];
        int                           cycle_count;

        cpu_top #(
                .STACK_POINTER (STACK_POINTER)
        ) u_dut (
                .i_clock             (clock),
                .i_reset             (reset),
                .i_fetch_instruction (fetch_instruction),
                .i_fetch_tag         (fetch_tag),
                .o_wb_rd             (wb_rd),
                .o_wb_value          (wb_value),
                .o_wb_tag            (wb_tag)
        );

        initial begin
                clock = 1'b0;
                forever #2 clock = ~clock;
        end

        task automatic report_failure(input string reason);
                $display("%s", reason);
                $display("FAIL: see errors above");
                $fatal(1, "stopped at first failure");
        endtask

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        report_failure($sformatf("Error at %0t: %s is %h, expected %h",
                                                 $time, what, got, expected));
                end
        endtask

        initial begin
                while (cycle_count < CYCLE_LIMIT) begin
                        @(posedge clock);
                        cycle_count++;
                end
                report_failure($sformatf("Timeout: run still busy after %0d cycles", CYCLE_LIMIT));
        end

        function automatic logic [31:0] next_random();
                logic [31:0] x;
                x = rng_state;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rng_state = x;
                return x;
        endfunction

        function automatic logic [4:0] pick_reg();
                logic [31:0] r;
                r = next_random();
                return (r[7:4] != 4'd0) ? {2'b00, r[2:0]} : r[12:8];   // mostly x0..x7 for hazards
        endfunction

        function automatic logic [31:0] alu_result(input int op, input logic [31:0] a,
                                                   input logic [31:0] b);
                case (op)
                        OP_ADD:  return a + b;
                        OP_SUB:  return a - b;
                        OP_SLL:  return a << b[4:0];
                        OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        OP_XOR:  return a ^ b;
                        OP_SRL:  return a >> b[4:0];
                        OP_OR:   return a | b;
                        default: return a & b;
                endcase
        endfunction

        function automatic logic [2:0] funct3_of(input int op);
                case (op)
                        OP_SLL:  return 3'b001;
                        OP_SLT:  return 3'b010;
                        OP_XOR:  return 3'b100;
                        OP_SRL:  return 3'b101;
                        OP_OR:   return 3'b110;
                        OP_AND:  return 3'b111;
                        default: return 3'b000;   // add and sub
                endcase
        endfunction

        // compare each tag change against the oldest expected result
        task automatic check_retire();
                if (wb_tag != last_wb_tag) begin
                        last_wb_tag = wb_tag;
                        if (exp_rd.size() == 0) begin
                                report_failure("A result retired with no instruction outstanding");
                        end else begin
                                check_value("retire cycle", cycle_count, exp_cycle.pop_front());
                                check_value("wb tag", wb_tag, exp_tag.pop_front());
                                check_value("wb rd", wb_rd, exp_rd.pop_front());
                                check_value("wb value", wb_value, exp_value.pop_front());
                        end
                end
        endtask

        task automatic idle_cycle();
                @(negedge clock);
                check_retire();
        endtask

        task automatic send(input logic [31:0] instr, input logic [4:0] rd,
                            input logic [31:0] value);
                @(negedge clock);
                check_retire();
                fetch_instruction = instr;
                fetch_tag = fetch_tag + 1'b1;
                exp_rd.push_back(rd);
                exp_value.push_back(value);
                exp_tag.push_back(fetch_tag);
                exp_cycle.push_back(cycle_count + 2);   // retire on the second rising edge
        endtask

        task automatic issue_op(input int op, input logic use_imm, input logic [4:0] rd,
                                input logic [4:0] rs1, input logic [4:0] rs2,
                                input logic [11:0] imm);
                logic [31:0] operand_b;
                logic [31:0] value;
                logic [31:0] instr;
                logic [6:0]  funct7;
                operand_b = use_imm ? {{20{imm[11]}}, imm} : model_regs[rs2];
                value = alu_result(op, model_regs[rs1], operand_b);
                funct7 = (op == OP_SUB) ? 7'b0100000 : 7'b0000000;
                if (use_imm)
                        instr = {imm, rs1, funct3_of(op), rd, 7'b0010011};
                else
                        instr = {funct7, rs2, rs1, funct3_of(op), rd, 7'b0110011};
                if (rd != 5'd0)
                        model_regs[rd] = value;
                send(instr, rd, value);
        endtask

        task automatic issue_illegal();
                logic [31:0] instr;
                logic [31:0] r;
                instr = next_random();
                r = next_random();
                case (r[1:0])
                        2'd0: begin
                                instr[6:0] = r[14:8];
                                if (instr[6:0] == 7'b0110011 || instr[6:0] == 7'b0010011)
                                        instr[2] = 1'b1;   // becomes lui or auipc
                        end
                        2'd1: begin
                                instr[31:25] = 7'b0000000;   // sltu
                                instr[14:12] = 3'b011;
                                instr[6:0]   = 7'b0110011;
                        end
                        2'd2: begin
                                instr[31:25] = 7'b0100000;   // sra
                                instr[14:12] = 3'b101;
                                instr[6:0]   = 7'b0110011;
                        end
                        default: begin
                                instr[14:12] = 3'b011;   // sltiu
                                instr[6:0]   = 7'b0010011;
                        end
                endcase
                send(instr, 5'd0, 32'h0);
        endtask

        initial begin
                logic [31:0] r;
                logic [11:0] imm;
                int          kind;
                int          op;
                int          count;
                rng_state = 32'hd43c_1ee4;
                reset = 1'b1;
                fetch_instruction = 32'h0;
                fetch_tag = '0;
                last_wb_tag = '0;
                for (int k = 0; k < 32; k++)
                        model_regs[k] = 32'h0;
                model_regs[2] = STACK_POINTER;
                repeat (3) @(negedge clock);
                reset = 1'b0;

                issue_op(OP_ADD, 1'b1, 5'd5, 5'd2, 5'd0, 12'd0);   // sp after reset
                issue_op(OP_ADD, 1'b1, 5'd6, 5'd7, 5'd0, 12'd0);
                issue_op(OP_ADD, 1'b1, 5'd1, 5'd0, 5'd0, 12'hffd);
                issue_op(OP_ADD, 1'b0, 5'd3, 5'd1, 5'd1, 12'd0);   // previous result
                issue_op(OP_SUB, 1'b0, 5'd4, 5'd3, 5'd1, 12'd0);   // both bypass paths
                issue_op(OP_SLT, 1'b0, 5'd9, 5'd4, 5'd0, 12'd0);
                issue_op(OP_SRL, 1'b1, 5'd10, 5'd4, 5'd0, 12'd28);
                issue_op(OP_ADD, 1'b1, 5'd0, 5'd2, 5'd0, 12'h123);
                issue_op(OP_OR, 1'b0, 5'd11, 5'd0, 5'd0, 12'd0);   // x0 still zero
                issue_illegal();

                count = 0;
                while (count < NUM_RANDOM) begin
                        r = next_random();
                        kind = r[11:8];
                        if (r[3:0] < 4'd3) begin
                                idle_cycle();   // tag held
                        end else begin
                                count++;
                                if (kind == 0) begin
                                        issue_illegal();
                                end else if (kind <= 8) begin
                                        issue_op(kind - 1, 1'b0, pick_reg(), pick_reg(),
                                                 pick_reg(), 12'd0);
                                end else begin
                                        op = imm_ops[kind - 9];
                                        imm = (op == OP_SLL || op == OP_SRL) ?
                                              {7'b0, r[20:16]} : r[31:20];
                                        issue_op(op, 1'b1, pick_reg(), pick_reg(), 5'd0, imm);
                                end
                        end
                end

                repeat (4) idle_cycle();   // last retire and a quiet tail

                if (exp_rd.size() != 0) begin
                        report_failure("Results were still outstanding at the end of the run");
                end else begin
                        $display("PASS: all tests");
                        $finish;
                end
        end

endmodule

`default_nettype wire
